/* logic/proc_config.svh */
// Processor memory and reset configuration
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Instruction memory size in 16-bit words
`define PROC_IMEM_DEPTH 256

// Data memory size in 16-bit words
`define PROC_DMEM_DEPTH 256

// First instruction fetched after reset
`define PROC_RESET_PC 16'h0000

`endif

/* logic/procPkg.sv */
// Processor shared types
package procPkg;

   // Opcode lives in instr[15:11], unlisted codes are illegal
   typedef enum logic [4:0] {
      NOP  = 5'd0,
      ADD  = 5'd1,
      SUB  = 5'd2,
      AND  = 5'd3,
      XOR  = 5'd4,
      ADDI = 5'd5,
      LBI  = 5'd6,
      LD   = 5'd7,
      ST   = 5'd8,
      BEQZ = 5'd9,
      BNEZ = 5'd10,
      J    = 5'd11,
      HALT = 5'd12
   } opcodeT;

   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_MEM,
      FWD_WB
   } fwdSelT;

   // R-type: ADD, SUB, AND, XOR
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] pad;
   } rFormatT;

   // ADDI, LD, ST (rd is the store data register for ST)
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } iFormatT;

   // LBI (regIdx is rd) and BEQZ/BNEZ (regIdx is rs)
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] regIdx;
      logic [7:0] imm;
   } wFormatT;

   typedef struct packed {
      logic [4:0]  opcode;
      logic [10:0] offset;
   } jFormatT;

   typedef struct packed {
      logic        valid;
      logic [15:0] pcInc;
      logic [15:0] instr;
   } fdBundleT;

   typedef struct packed {
      logic        valid;
      opcodeT      opcode;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [15:0] opA;
      logic [15:0] opB;
      logic [15:0] imm;
      logic [15:0] pcInc;
      logic [2:0]  dest;
      logic        writesReg;
      logic        readsMem;
      logic        writesMem;
      logic        isHalt;
      logic        isIllegal;
   } dxBundleT;

   typedef struct packed {
      logic        valid;
      logic [15:0] result;
      logic [15:0] storeData;
      logic [2:0]  dest;
      logic        writesReg;
      logic        readsMem;
      logic        writesMem;
      logic        isHalt;
      logic        isIllegal;
   } xmBundleT;

   typedef struct packed {
      logic        valid;
      logic [2:0]  dest;
      logic [15:0] value;
      logic        writesReg;
      logic        isHalt;
      logic        isIllegal;
   } wbBundleT;

endpackage

/* logic/fetchStage.sv */
// Instruction fetch stage
`timescale 1ns/10ps
`include "proc_config.svh"

module fetchStage (
   input  logic              clk,
   input  logic              rstN,
   input  logic              progWrEn,
   input  logic [7:0]        progAddr,
   input  logic [15:0]       progData,
   input  logic              stall,
   input  logic              flush,
   input  logic              redirect,
   input  logic [15:0]       redirectPc,
   input  logic              halted,
   output procPkg::fdBundleT fetchOut
);

   localparam int IMEM_AW = $clog2(`PROC_IMEM_DEPTH);

   logic [15:0] imem [`PROC_IMEM_DEPTH];
   logic [15:0] pc;
   logic [15:0] pcInc;
   logic [15:0] instr;

   assign pcInc = pc + 16'd1;
   assign instr = imem[pc[IMEM_AW-1:0]];

   // Program port, only driven while the core is in reset
   always_ff @(posedge clk) begin
      if (progWrEn) begin
         imem[progAddr] <= progData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= `PROC_RESET_PC;
      end else if (halted) begin
         pc <= pc;
      end else if (redirect) begin
         pc <= redirectPc;
      end else if (!stall) begin
         pc <= pcInc;
      end
   end

   // Fetch/decode register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         fetchOut <= '0;
      end else if (flush) begin
         fetchOut.valid <= 1'b0;
      end else if (!stall) begin
         fetchOut.valid <= !halted;
         fetchOut.pcInc <= pcInc;
         fetchOut.instr <= instr;
      end
   end

   progDuringReset: assert property (@(posedge clk) rstN |-> !progWrEn)
      else $error("program port written outside reset");

endmodule

/* logic/regFile.sv */
// General register file
`timescale 1ns/10ps

module regFile (
   input  logic              clk,
   input  logic              rstN,
   input  logic [2:0]        rdAddrA,
   input  logic [2:0]        rdAddrB,
   output logic [15:0]       rdDataA,
   output logic [15:0]       rdDataB,
   input  procPkg::wbBundleT wbIn
);

   logic [15:0] regs [8];
   logic        wrEn;

   assign wrEn = wbIn.valid && wbIn.writesReg;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (wrEn) begin
         regs[wbIn.dest] <= wbIn.value;
      end
   end

   // Same-cycle writeback bypass so decode sees the retiring value
   always_comb begin
      if (wrEn && wbIn.dest == rdAddrA) begin
         rdDataA = wbIn.value;
      end else begin
         rdDataA = regs[rdAddrA];
      end
      if (wrEn && wbIn.dest == rdAddrB) begin
         rdDataB = wbIn.value;
      end else begin
         rdDataB = regs[rdAddrB];
      end
   end

endmodule

/* logic/decodeStage.sv */
// Instruction decode stage
`timescale 1ns/10ps

module decodeStage (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::fdBundleT decodeIn,
   input  logic              stall,
   input  logic              flush,
   output logic [2:0]        rdAddrA,
   output logic [2:0]        rdAddrB,
   input  logic [15:0]       rdDataA,
   input  logic [15:0]       rdDataB,
   output procPkg::dxBundleT decodeOut
);

   import procPkg::*;

   opcodeT   op;
   rFormatT  rFmt;
   iFormatT  iFmt;
   wFormatT  wFmt;
   jFormatT  jFmt;
   dxBundleT next;

   assign op   = opcodeT'(decodeIn.instr[15:11]);
   assign rFmt = rFormatT'(decodeIn.instr);
   assign iFmt = iFormatT'(decodeIn.instr);
   assign wFmt = wFormatT'(decodeIn.instr);
   assign jFmt = jFormatT'(decodeIn.instr);

   // Port A is always bits 10..8, port B is rt for R-type and ST
   assign rdAddrA = rFmt.rs;
   assign rdAddrB = (op inside {ADD, SUB, AND, XOR, ST}) ? rFmt.rt : rFmt.rs;

   always_comb begin
      next           = '0;
      next.valid     = decodeIn.valid;
      next.opcode    = op;
      next.rs        = rdAddrA;
      next.rt        = rdAddrB;
      next.opA       = rdDataA;
      next.opB       = rdDataB;
      next.pcInc     = decodeIn.pcInc;
      case (op)
         ADD, SUB, AND, XOR: begin
            next.dest      = rFmt.rd;
            next.writesReg = 1'b1;
         end
         ADDI, LD: begin
            next.imm       = {{11{iFmt.imm[4]}}, iFmt.imm};
            next.dest      = iFmt.rd;
            next.writesReg = 1'b1;
            next.readsMem  = (op == LD);
         end
         ST: begin
            next.imm       = {{11{iFmt.imm[4]}}, iFmt.imm};
            next.writesMem = 1'b1;
         end
         LBI: begin
            next.imm       = {{8{wFmt.imm[7]}}, wFmt.imm};
            next.dest      = wFmt.regIdx;
            next.writesReg = 1'b1;
         end
         BEQZ, BNEZ: begin
            next.imm = {{8{wFmt.imm[7]}}, wFmt.imm};
         end
         J: begin
            next.imm = {{5{jFmt.offset[10]}}, jFmt.offset};
         end
         HALT: begin
            next.isHalt = 1'b1;
         end
         NOP: begin
            next.opcode = NOP;
         end
         default: begin
            // Undefined code retires as a halt that also raises err
            next.opcode    = NOP;
            next.isHalt    = 1'b1;
            next.isIllegal = 1'b1;
         end
      endcase
   end

   // Decode/execute register, stall drops a bubble in
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decodeOut <= '0;
      end else begin
         decodeOut       <= next;
         decodeOut.valid <= next.valid && !stall && !flush;
      end
   end

   memDirExclusive: assert property (@(posedge clk) disable iff (!rstN)
      decodeOut.valid |-> !(decodeOut.readsMem && decodeOut.writesMem))
      else $error("instruction both reads and writes data memory");

endmodule

/* logic/hazardUnit.sv */
// Forwarding, stall and flush control
`timescale 1ns/10ps

module hazardUnit (
   input  procPkg::dxBundleT dxIn,
   input  procPkg::xmBundleT xmIn,
   input  procPkg::wbBundleT wbIn,
   input  logic [2:0]        decodeRs,
   input  logic [2:0]        decodeRt,
   input  logic              redirect,
   output logic              stall,
   output logic              flush,
   output procPkg::fwdSelT   fwdA,
   output procPkg::fwdSelT   fwdB
);

   import procPkg::*;

   logic memWrites;
   logic wbWrites;

   assign memWrites = xmIn.valid && xmIn.writesReg;
   assign wbWrites  = wbIn.valid && wbIn.writesReg;

   // Youngest producer wins, so memory stage beats writeback
   function automatic fwdSelT pickFwd(input logic [2:0] src);
      fwdSelT sel;
      sel = FWD_NONE;
      if (memWrites && xmIn.dest == src) begin
         sel = FWD_MEM;
      end else if (wbWrites && wbIn.dest == src) begin
         sel = FWD_WB;
      end
      return sel;
   endfunction

   assign fwdA = pickFwd(dxIn.rs);
   assign fwdB = pickFwd(dxIn.rt);

   // Load data only exists after the memory stage
   assign stall = dxIn.valid && dxIn.readsMem && dxIn.writesReg &&
                  (dxIn.dest == decodeRs || dxIn.dest == decodeRt);

   assign flush = redirect;

   // A load in execute never redirects, so stall and flush stay apart
   always_comb begin
      stallFlushApart: assert final (!(stall && flush))
         else $error("load-use stall coincides with a redirect");
   end

endmodule

/* logic/executeStage.sv */
// Execute stage with ALU and branch resolution
`timescale 1ns/10ps

module executeStage (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::dxBundleT execIn,
   input  procPkg::fwdSelT   fwdA,
   input  procPkg::fwdSelT   fwdB,
   input  logic [15:0]       memFwd,
   input  procPkg::wbBundleT wbFwd,
   output logic              redirect,
   output logic [15:0]       redirectPc,
   output procPkg::xmBundleT execOut
);

   import procPkg::*;

   logic [15:0] opA;
   logic [15:0] opB;
   logic [15:0] result;
   logic        taken;

   always_comb begin
      case (fwdA)
         FWD_MEM: opA = memFwd;
         FWD_WB:  opA = wbFwd.value;
         default: opA = execIn.opA;
      endcase
      case (fwdB)
         FWD_MEM: opB = memFwd;
         FWD_WB:  opB = wbFwd.value;
         default: opB = execIn.opB;
      endcase
   end

   always_comb begin
      result = '0;
      taken  = 1'b0;
      case (execIn.opcode)
         ADD:          result = opA + opB;
         SUB:          result = opA - opB;
         AND:          result = opA & opB;
         XOR:          result = opA ^ opB;
         ADDI, LD, ST: result = opA + execIn.imm;
         LBI:          result = execIn.imm;
         BEQZ:         taken  = (opA == 16'd0);
         BNEZ:         taken  = (opA != 16'd0);
         J:            taken  = 1'b1;
         default:      result = '0;
      endcase
   end

   // Offsets are in words from the incremented PC
   assign redirect   = execIn.valid && taken;
   assign redirectPc = execIn.pcInc + execIn.imm;

   // Execute/memory register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         execOut <= '0;
      end else begin
         execOut.valid     <= execIn.valid;
         execOut.result    <= result;
         execOut.storeData <= opB;
         execOut.dest      <= execIn.dest;
         execOut.writesReg <= execIn.writesReg;
         execOut.readsMem  <= execIn.readsMem;
         execOut.writesMem <= execIn.writesMem;
         execOut.isHalt    <= execIn.isHalt;
         execOut.isIllegal <= execIn.isIllegal;
      end
   end

endmodule

/* logic/memoryStage.sv */
// Memory access stage and writeback register
`timescale 1ns/10ps
`include "proc_config.svh"

module memoryStage (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::xmBundleT memIn,
   output procPkg::wbBundleT memOut,
   output logic              halted,
   output logic              err
);

   localparam int DMEM_AW = $clog2(`PROC_DMEM_DEPTH);

   logic [15:0]        dmem [`PROC_DMEM_DEPTH];
   logic [DMEM_AW-1:0] addr;
   logic               live;

   // Nothing younger than a retired HALT may have side effects
   assign live = memIn.valid && !halted;
   assign addr = memIn.result[DMEM_AW-1:0];

   always_ff @(posedge clk) begin
      if (live && memIn.writesMem) begin
         dmem[addr] <= memIn.storeData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         memOut <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         memOut.valid     <= live;
         memOut.dest      <= memIn.dest;
         memOut.value     <= memIn.readsMem ? dmem[addr] : memIn.result;
         memOut.writesReg <= memIn.writesReg;
         memOut.isHalt    <= memIn.isHalt;
         memOut.isIllegal <= memIn.isIllegal;
         // Sticky, rise together with the bundle entering writeback
         halted <= halted || (live && memIn.isHalt);
         err    <= err || (live && memIn.isIllegal);
      end
   end

   addrInRange: assert property (@(posedge clk) disable iff (!rstN)
      (live && (memIn.readsMem || memIn.writesMem)) |-> memIn.result < `PROC_DMEM_DEPTH)
      else $error("data memory address out of range");

endmodule

/* logic/proc.sv */
// Five-stage pipelined processor
`timescale 1ns/10ps

module proc (
   input  logic              clk,
   input  logic              rstN,
   input  logic              progWrEn,
   input  logic [7:0]        progAddr,
   input  logic [15:0]       progData,
   output procPkg::wbBundleT wbTrace,
   output logic              halted,
   output logic              err
);

   import procPkg::*;

   fdBundleT    fdBundle;
   dxBundleT    dxBundle;
   xmBundleT    xmBundle;
   logic [2:0]  rdAddrA;
   logic [2:0]  rdAddrB;
   logic [15:0] rdDataA;
   logic [15:0] rdDataB;
   logic        stall;
   logic        flush;
   logic        redirect;
   logic [15:0] redirectPc;
   fwdSelT      fwdA;
   fwdSelT      fwdB;

   fetchStage fetchStage (
      .clk(clk), .rstN(rstN),
      .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
      .stall(stall), .flush(flush),
      .redirect(redirect), .redirectPc(redirectPc),
      .halted(halted),
      .fetchOut(fdBundle)
   );

   decodeStage decodeStage (
      .clk(clk), .rstN(rstN),
      .decodeIn(fdBundle),
      .stall(stall), .flush(flush),
      .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .decodeOut(dxBundle)
   );

   regFile regFile (
      .clk(clk), .rstN(rstN),
      .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .wbIn(wbTrace)
   );

   hazardUnit hazardUnit (
      .dxIn(dxBundle), .xmIn(xmBundle), .wbIn(wbTrace),
      .decodeRs(rdAddrA), .decodeRt(rdAddrB),
      .redirect(redirect),
      .stall(stall), .flush(flush),
      .fwdA(fwdA), .fwdB(fwdB)
   );

   executeStage executeStage (
      .clk(clk), .rstN(rstN),
      .execIn(dxBundle),
      .fwdA(fwdA), .fwdB(fwdB),
      .memFwd(xmBundle.result), .wbFwd(wbTrace),
      .redirect(redirect), .redirectPc(redirectPc),
      .execOut(xmBundle)
   );

   // Writeback bundle doubles as the trace port
   memoryStage memoryStage (
      .clk(clk), .rstN(rstN),
      .memIn(xmBundle),
      .memOut(wbTrace),
      .halted(halted), .err(err)
   );

endmodule

/* test/tbPrograms.svh */
// Test programs and expected traces
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_PROGS  = 6;
localparam int MAX_WORDS  = 20;
localparam int MAX_WRITES = 12;

localparam logic [15:0] HALT_WORD    = {HALT, 11'd0};
localparam logic [15:0] ILLEGAL_WORD = 16'hf800;

// One retired register write
typedef struct packed {
   logic [2:0]  dest;
   logic [15:0] value;
} traceEntryT;

logic [15:0] progWords [NUM_PROGS][MAX_WORDS];
int          progLen   [NUM_PROGS];
traceEntryT  expTrace  [NUM_PROGS][MAX_WRITES];
int          expLen    [NUM_PROGS];
logic        expErr    [NUM_PROGS];

// Instruction encoders, one per format
function automatic logic [15:0] aluOp(input opcodeT op, input int rs, input int rt,
                                      input int rd);
   return {op, rs[2:0], rt[2:0], rd[2:0], 2'b00};
endfunction

function automatic logic [15:0] immOp(input opcodeT op, input int rs, input int rd,
                                      input int imm);
   return {op, rs[2:0], rd[2:0], imm[4:0]};
endfunction

function automatic logic [15:0] wideOp(input opcodeT op, input int idx, input int imm);
   return {op, idx[2:0], imm[7:0]};
endfunction

function automatic logic [15:0] jumpTo(input int offset);
   return {J, offset[10:0]};
endfunction

function automatic logic [15:0] signExtend8(input logic [7:0] v);
   return {{8{v[7]}}, v};
endfunction

function automatic void addWord(input int p, input logic [15:0] w);
   progWords[p][progLen[p]] = w;
   progLen[p]++;
endfunction

function automatic void expectWrite(input int p, input int dest, input logic [15:0] value);
   expTrace[p][expLen[p]] = traceEntryT'({dest[2:0], value});
   expLen[p]++;
endfunction

// Dependent ALU chain on random LBI operands
function automatic void addAluChain(input int p);
   logic [7:0]  a;
   logic [7:0]  b;
   logic [7:0]  c;
   logic [15:0] va;
   logic [15:0] vb;
   logic [15:0] vc;
   logic [15:0] sum;
   logic [15:0] diff;
   logic [15:0] both;
   logic [15:0] mix;

   a    = randomByte();
   b    = randomByte();
   c    = randomByte();
   va   = signExtend8(a);
   vb   = signExtend8(b);
   vc   = signExtend8(c);
   sum  = va + vb;
   diff = sum - va;
   both = diff & sum;
   mix  = both ^ vb;
   addWord(p, wideOp(LBI, 1, a));
   expectWrite(p, 1, va);
   addWord(p, wideOp(LBI, 2, b));
   expectWrite(p, 2, vb);
   // Operands come from memory stage, writeback and register file
   addWord(p, aluOp(ADD, 1, 2, 3));
   expectWrite(p, 3, sum);
   addWord(p, aluOp(SUB, 3, 1, 4));
   expectWrite(p, 4, diff);
   addWord(p, aluOp(AND, 4, 3, 5));
   expectWrite(p, 5, both);
   addWord(p, aluOp(XOR, 5, 2, 6));
   expectWrite(p, 6, mix);
   addWord(p, immOp(ADDI, 6, 7, -3));
   expectWrite(p, 7, mix - 16'd3);
   addWord(p, wideOp(LBI, 1, c));
   expectWrite(p, 1, vc);
   addWord(p, aluOp(ADD, 1, 1, 1));
   expectWrite(p, 1, vc + vc);
   addWord(p, HALT_WORD);
endfunction

function automatic void buildPrograms();
   for (int p = 0; p < NUM_PROGS; p++) begin
      progLen[p] = 0;
      expLen[p]  = 0;
      expErr[p]  = 1'b0;
   end
   addAluChain(0);
   addAluChain(1);

   // Store, load back, and consume each load right away
   addWord(2, wideOp(LBI, 1, 20));
   expectWrite(2, 1, 16'd20);
   addWord(2, wideOp(LBI, 2, -7));
   expectWrite(2, 2, 16'hfff9);
   addWord(2, immOp(ST, 1, 2, 3));
   addWord(2, immOp(LD, 1, 3, 3));
   expectWrite(2, 3, 16'hfff9);
   addWord(2, aluOp(ADD, 3, 3, 4));
   expectWrite(2, 4, 16'hfff2);
   addWord(2, immOp(LD, 1, 5, 3));
   expectWrite(2, 5, 16'hfff9);
   addWord(2, aluOp(SUB, 1, 5, 6));
   expectWrite(2, 6, 16'd27);
   addWord(2, HALT_WORD);

   // Taken branches skip two words, untaken ones fall through
   addWord(3, wideOp(LBI, 1, 0));
   expectWrite(3, 1, 16'd0);
   addWord(3, wideOp(LBI, 2, 5));
   expectWrite(3, 2, 16'd5);
   addWord(3, wideOp(BEQZ, 1, 2));
   addWord(3, wideOp(LBI, 3, 1));
   addWord(3, wideOp(LBI, 3, 2));
   addWord(3, wideOp(BNEZ, 2, 2));
   addWord(3, wideOp(LBI, 4, 3));
   addWord(3, wideOp(LBI, 4, 4));
   addWord(3, wideOp(BEQZ, 2, 1));
   addWord(3, wideOp(LBI, 5, 6));
   expectWrite(3, 5, 16'd6);
   addWord(3, wideOp(BNEZ, 1, 1));
   addWord(3, wideOp(LBI, 6, 7));
   expectWrite(3, 6, 16'd7);
   addWord(3, wideOp(LBI, 3, 4));
   expectWrite(3, 3, 16'd4);
   addWord(3, wideOp(BNEZ, 3, 2));
   addWord(3, wideOp(LBI, 7, 9));
   addWord(3, wideOp(LBI, 7, 10));
   addWord(3, HALT_WORD);

   // Forward jumps over a HALT, then a backward jump onto one
   addWord(4, wideOp(LBI, 1, 3));
   expectWrite(4, 1, 16'd3);
   addWord(4, jumpTo(2));
   addWord(4, wideOp(LBI, 1, 9));
   addWord(4, HALT_WORD);
   addWord(4, immOp(ADDI, 1, 2, 4));
   expectWrite(4, 2, 16'd7);
   addWord(4, jumpTo(3));
   addWord(4, HALT_WORD);
   addWord(4, wideOp(LBI, 3, 1));
   addWord(4, wideOp(LBI, 3, 2));
   addWord(4, jumpTo(-4));
   addWord(4, wideOp(LBI, 4, 1));
   addWord(4, wideOp(LBI, 4, 2));

   addWord(5, wideOp(LBI, 1, 12));
   expectWrite(5, 1, 16'd12);
   addWord(5, immOp(ADDI, 1, 2, -5));
   expectWrite(5, 2, 16'd7);
   addWord(5, ILLEGAL_WORD);
   addWord(5, wideOp(LBI, 3, 1));
   addWord(5, HALT_WORD);
   expErr[5] = 1'b1;
endfunction

`endif

/* test/procTb.sv */
// Pipelined processor testbench
`timescale 1ns/10ps

module procTb;

   import procPkg::*;

   localparam int RESET_CYCLES = 10;
   localparam int RUN_TIMEOUT  = 300;
   localparam int QUIET_CYCLES = 8;

   logic        clk;
   logic        rstN;
   logic        progWrEn;
   logic [7:0]  progAddr;
   logic [15:0] progData;
   wbBundleT    wbTrace;
   logic        halted;
   logic        err;
   logic [31:0] lcgState;

   // LCG step, operand taken from the upper half
   function automatic logic [7:0] randomByte();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState[23:16];
   endfunction

   `include "tbPrograms.svh"

   proc UUT (
      .clk(clk),
      .rstN(rstN),
      .progWrEn(progWrEn),
      .progAddr(progAddr),
      .progData(progData),
      .wbTrace(wbTrace),
      .halted(halted),
      .err(err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   // Reset, load through the program port, run to halt and check the trace
   task automatic runProgram(input int p);
      traceEntryT seen [$];
      int         holdCycles;
      int         cycles;
      logic       wrNow;

      holdCycles = (progLen[p] > RESET_CYCLES) ? progLen[p] : RESET_CYCLES;
      @(negedge clk);
      rstN = 1'b0;
      for (int w = 0; w < holdCycles; w++) begin
         @(negedge clk);
         wrNow    = (w < progLen[p]);
         progWrEn = wrNow;
         progAddr = 8'(w);
         progData = wrNow ? progWords[p][w] : 16'h0000;
      end
      @(negedge clk);
      progWrEn = 1'b0;
      assert (!halted && !err && !wbTrace.valid)
         else reportFailure($sformatf("[FAIL] %0t: program %0d status not clear in reset",
                                      $time, p));
      rstN = 1'b1;

      cycles = 0;
      while (!halted && cycles < RUN_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         if (wbTrace.valid && wbTrace.writesReg) begin
            seen.push_back(traceEntryT'({wbTrace.dest, wbTrace.value}));
         end
      end
      if (!halted) begin
         reportFailure($sformatf("Timeout: program %0d did not halt within %0d cycles",
                                 p, RUN_TIMEOUT));
      end

      assert (wbTrace.valid && wbTrace.isHalt)
         else reportFailure($sformatf("[FAIL] %0t: program %0d halted without a halt in writeback",
                                      $time, p));
      // The stopping instruction is flagged illegal only for an undefined opcode
      assert (wbTrace.isIllegal == expErr[p])
         else reportFailure($sformatf("[FAIL] %0t: program %0d halt illegal=%b, expected %b",
                                      $time, p, wbTrace.isIllegal, expErr[p]));
      assert (err == expErr[p])
         else reportFailure($sformatf("[FAIL] %0t: program %0d err=%b, expected %b",
                                      $time, p, err, expErr[p]));
      assert (seen.size() == expLen[p])
         else reportFailure($sformatf("[FAIL] %0t: program %0d retired %0d writes, expected %0d",
                                      $time, p, seen.size(), expLen[p]));
      for (int k = 0; k < expLen[p]; k++) begin
         assert (seen[k] == expTrace[p][k])
            else reportFailure($sformatf("[FAIL] %0t: program %0d write %0d r%0d=%h, expected r%0d=%h",
                                         $time, p, k, seen[k].dest, seen[k].value,
                                         expTrace[p][k].dest, expTrace[p][k].value));
      end

      // Nothing may retire once the core has stopped
      for (int k = 0; k < QUIET_CYCLES; k++) begin
         @(negedge clk);
         assert (halted && !wbTrace.valid)
            else reportFailure($sformatf("[FAIL] %0t: program %0d trace active after halt",
                                         $time, p));
         assert (err == expErr[p])
            else reportFailure($sformatf("[FAIL] %0t: program %0d err changed after halt",
                                         $time, p));
      end
      $display("Program %0d done, %0d writes", p, seen.size());
   endtask

   initial begin
      rstN     = 1'b0;
      progWrEn = 1'b0;
      progAddr = '0;
      progData = '0;
      lcgState = 32'hdc18_43cd;
      buildPrograms();
      for (int p = 0; p < NUM_PROGS; p++) begin
         runProgram(p);
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+logic
+incdir+test
logic/procPkg.sv
logic/fetchStage.sv
logic/regFile.sv
logic/decodeStage.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/proc.sv
test/procTb.sv
